//--- src/rv_settings.svh
//////////////////////////////
// RV32I core settings
// Datapath width, register file size and boot address
//////////////////////////////

`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data and address width
`define RV_XLEN 32

// Number of integer registers
`define RV_REG_NUM 32

// Register index width
`define RV_REG_ADDR_W 5

// First fetch address out of reset
`define RV_BOOT_ADDR 32'h0000_0000

`endif

//--- src/rv_pkg.sv
//////////////////////////////
// RV32I core types
// Encodings and buses shared between the pipeline stages
//////////////////////////////

`include "rv_settings.svh"

package rv_pkg;

    // Size of one instruction word in bytes
    localparam logic [`RV_XLEN-1:0] inst_bytes = 4;

    //////////////////////////////
    // Encodings
    //////////////////////////////

    typedef enum logic [2:0] {
        class_op,
        class_op_imm,
        class_lui,
        class_jal,
        class_branch,
        class_system,
        class_illegal
    } inst_class_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_request,
        fetch_wait_done
    } fetch_state_e;

    //////////////////////////////
    // Buses
    //////////////////////////////

    // Wishbone master side
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [`RV_XLEN-1:0] adr;
    } wb_req_t;

    // Wishbone slave side
    typedef struct packed {
        logic                ack;
        logic [`RV_XLEN-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] instr;
    } fetched_t;

    typedef struct packed {
        logic                      valid;
        inst_class_e               cls;
        alu_op_e                   alu_op;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       op_a;
        logic [`RV_XLEN-1:0]       op_b;
        logic [`RV_XLEN-1:0]       rs2_val;
        logic [`RV_XLEN-1:0]       imm;
        logic [`RV_XLEN-1:0]       pc;
        logic [2:0]                funct3;
    } decoded_t;

    typedef struct packed {
        logic ecall;
        logic ebreak;
        logic illegal;
    } trap_t;

    // Carries the pc along for the retire report
    typedef struct packed {
        logic                      valid;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       value;
        logic [`RV_XLEN-1:0]       pc;
        logic [`RV_XLEN-1:0]       next_pc;
        trap_t                     trap;
    } exec_result_t;

    typedef struct packed {
        logic                      valid;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       value;
        logic [`RV_XLEN-1:0]       pc;
    } retire_t;

endpackage

//--- src/rv_fetch.sv
//////////////////////////////
// Instruction fetch
// One Wishbone classic read per retired instruction
//////////////////////////////

`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_fetch (
    input  logic                aclk,
    input  logic                rst_n,
    output rv_pkg::wb_req_t     ibus_req,
    input  rv_pkg::wb_rsp_t     ibus_rsp,
    output rv_pkg::fetched_t    fetched,
    input  logic                done,
    input  logic [`RV_XLEN-1:0] next_pc
);

    rv_pkg::fetch_state_e state;
    logic [`RV_XLEN-1:0]  pc;

    //////////////////////////////
    // Fetch FSM
    //////////////////////////////

    // idle only follows reset; after the first request the FSM moves
    // between request and wait_done
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state <= rv_pkg::fetch_idle;
            pc    <= `RV_BOOT_ADDR;
        end else begin
            case (state)
                rv_pkg::fetch_idle: begin
                    state <= rv_pkg::fetch_request;
                end
                rv_pkg::fetch_request: begin
                    // Slave may insert any number of wait states
                    if (ibus_rsp.ack) begin
                        state <= rv_pkg::fetch_wait_done;
                    end
                end
                rv_pkg::fetch_wait_done: begin
                    // No done after a trap, so the core halts here
                    if (done) begin
                        pc    <= next_pc;
                        state <= rv_pkg::fetch_request;
                    end
                end
                default: begin
                    state <= rv_pkg::fetch_idle;
                end
            endcase
        end
    end

    //////////////////////////////
    // Bus and instruction outputs
    //////////////////////////////

    // Read cycle only, address held by the pc register until ack
    assign ibus_req.cyc = (state == rv_pkg::fetch_request);
    assign ibus_req.stb = (state == rv_pkg::fetch_request);
    assign ibus_req.we  = 1'b0;
    assign ibus_req.adr = pc;

    // Instruction word is taken in the ack cycle
    assign fetched.valid = (state == rv_pkg::fetch_request) && ibus_rsp.ack;
    assign fetched.pc    = pc;
    assign fetched.instr = ibus_rsp.dat;

endmodule

//--- src/rv_decode.sv
//////////////////////////////
// Instruction decode
// Field split, immediates, classification and operand read
//////////////////////////////

`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_decode (
    input  logic                      aclk,
    input  logic                      rst_n,
    input  rv_pkg::fetched_t          fetched,
    output logic [`RV_REG_ADDR_W-1:0] rs1_addr,
    output logic [`RV_REG_ADDR_W-1:0] rs2_addr,
    input  logic [`RV_XLEN-1:0]       rs1_val,
    input  logic [`RV_XLEN-1:0]       rs2_val,
    output rv_pkg::decoded_t          decoded
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_j;
    rv_pkg::decoded_t    dec;

    // ALU operation shared by OP and OP-IMM for the plain funct7 case
    function automatic rv_pkg::alu_op_e base_alu(input logic [2:0] f3);
        case (f3)
            3'b001:  return rv_pkg::alu_sll;
            3'b010:  return rv_pkg::alu_slt;
            3'b011:  return rv_pkg::alu_sltu;
            3'b100:  return rv_pkg::alu_xor;
            3'b101:  return rv_pkg::alu_srl;
            3'b110:  return rv_pkg::alu_or;
            3'b111:  return rv_pkg::alu_and;
            default: return rv_pkg::alu_add;
        endcase
    endfunction

    //////////////////////////////
    // Fields and immediates
    //////////////////////////////

    assign opcode   = fetched.instr[6:0];
    assign funct3   = fetched.instr[14:12];
    assign funct7   = fetched.instr[31:25];
    assign rs1_addr = fetched.instr[19:15];
    assign rs2_addr = fetched.instr[24:20];

    assign imm_i = {{20{fetched.instr[31]}}, fetched.instr[31:20]};
    assign imm_u = {fetched.instr[31:12], 12'b0};
    assign imm_b = {{19{fetched.instr[31]}}, fetched.instr[31], fetched.instr[7],
                    fetched.instr[30:25], fetched.instr[11:8], 1'b0};
    assign imm_j = {{11{fetched.instr[31]}}, fetched.instr[31], fetched.instr[19:12],
                    fetched.instr[20], fetched.instr[30:21], 1'b0};

    //////////////////////////////
    // Classification
    //////////////////////////////

    always_comb begin
        dec         = '0;
        dec.valid   = fetched.valid;
        dec.cls     = rv_pkg::class_illegal;
        dec.alu_op  = rv_pkg::alu_add;
        dec.rd      = fetched.instr[11:7];
        dec.op_a    = rs1_val;
        dec.op_b    = rs2_val;
        dec.rs2_val = rs2_val;
        dec.imm     = imm_i;
        dec.pc      = fetched.pc;
        dec.funct3  = funct3;
        case (opcode)
            7'b0110011: begin
                if (funct7 == 7'b0000000) begin
                    dec.cls    = rv_pkg::class_op;
                    dec.alu_op = base_alu(funct3);
                end else if (funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101}) begin
                    dec.cls    = rv_pkg::class_op;
                    dec.alu_op = funct3[2] ? rv_pkg::alu_sra : rv_pkg::alu_sub;
                end
            end
            7'b0010011: begin
                dec.op_b = imm_i;
                // SLTIU is outside the kept subset
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    if (funct7 == 7'b0000000) begin
                        dec.cls    = rv_pkg::class_op_imm;
                        dec.alu_op = base_alu(funct3);
                    end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
                        dec.cls    = rv_pkg::class_op_imm;
                        dec.alu_op = rv_pkg::alu_sra;
                    end
                end else if (funct3 != 3'b011) begin
                    dec.cls    = rv_pkg::class_op_imm;
                    dec.alu_op = base_alu(funct3);
                end
            end
            7'b0110111: begin
                dec.cls    = rv_pkg::class_lui;
                dec.alu_op = rv_pkg::alu_pass_b;
                dec.op_b   = imm_u;
                dec.imm    = imm_u;
            end
            7'b1101111: begin
                // Link value is pc + 4
                dec.cls  = rv_pkg::class_jal;
                dec.op_a = fetched.pc;
                dec.op_b = rv_pkg::inst_bytes;
                dec.imm  = imm_j;
            end
            7'b1100011: begin
                dec.imm = imm_b;
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    dec.cls = rv_pkg::class_branch;
                end
            end
            7'b1110011: begin
                // ECALL and EBREAK only, told apart by immediate bit 0
                if (fetched.instr[31:21] == '0 && fetched.instr[19:7] == '0) begin
                    dec.cls = rv_pkg::class_system;
                end
            end
            default: begin
                dec.cls = rv_pkg::class_illegal;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            decoded <= '0;
        end else begin
            decoded <= dec;
        end
    end

endmodule

//--- src/rv_execute.sv
//////////////////////////////
// Execute stage
// ALU, branch compare, next pc and trap detection
//////////////////////////////

`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_execute (
    input  logic                 aclk,
    input  logic                 rst_n,
    input  rv_pkg::decoded_t     decoded,
    output rv_pkg::exec_result_t result
);

    logic [4:0]           shamt;
    logic [`RV_XLEN-1:0]  alu_val;
    logic                 taken;
    rv_pkg::exec_result_t res;

    //////////////////////////////
    // ALU
    //////////////////////////////

    assign shamt = decoded.op_b[4:0];

    always_comb begin
        case (decoded.alu_op)
            rv_pkg::alu_add:    alu_val = decoded.op_a + decoded.op_b;
            rv_pkg::alu_sub:    alu_val = decoded.op_a - decoded.op_b;
            rv_pkg::alu_and:    alu_val = decoded.op_a & decoded.op_b;
            rv_pkg::alu_or:     alu_val = decoded.op_a | decoded.op_b;
            rv_pkg::alu_xor:    alu_val = decoded.op_a ^ decoded.op_b;
            rv_pkg::alu_sll:    alu_val = decoded.op_a << shamt;
            rv_pkg::alu_srl:    alu_val = decoded.op_a >> shamt;
            rv_pkg::alu_sra:    alu_val = $signed(decoded.op_a) >>> shamt;
            rv_pkg::alu_slt:    alu_val = {{(`RV_XLEN-1){1'b0}},
                                           $signed(decoded.op_a) < $signed(decoded.op_b)};
            rv_pkg::alu_sltu:   alu_val = {{(`RV_XLEN-1){1'b0}}, decoded.op_a < decoded.op_b};
            rv_pkg::alu_pass_b: alu_val = decoded.op_b;
            default:            alu_val = '0;
        endcase
    end

    // BEQ on funct3 000, BNE otherwise
    assign taken = (decoded.funct3 == 3'b000) ? (decoded.op_a == decoded.rs2_val)
                                              : (decoded.op_a != decoded.rs2_val);

    //////////////////////////////
    // Result and control flow
    //////////////////////////////

    always_comb begin
        res         = '0;
        res.valid   = decoded.valid;
        res.rd      = decoded.rd;
        res.value   = alu_val;
        res.pc      = decoded.pc;
        res.next_pc = decoded.pc + rv_pkg::inst_bytes;
        case (decoded.cls)
            rv_pkg::class_jal: begin
                res.next_pc = decoded.pc + decoded.imm;
            end
            rv_pkg::class_branch: begin
                res.rd    = '0;
                res.value = '0;
                if (taken) begin
                    res.next_pc = decoded.pc + decoded.imm;
                end
            end
            rv_pkg::class_system: begin
                res.rd          = '0;
                res.value       = '0;
                res.trap.ebreak = decoded.imm[0];
                res.trap.ecall  = !decoded.imm[0];
            end
            rv_pkg::class_illegal: begin
                res.rd           = '0;
                res.value        = '0;
                res.trap.illegal = 1'b1;
            end
            default: begin
                res.rd = decoded.rd;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result <= res;
        end
    end

endmodule

//--- src/rv_result.sv
//////////////////////////////
// Write-back stage
// Register file, retire report and sticky trap status
//////////////////////////////

`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_result (
    input  logic                      aclk,
    input  logic                      rst_n,
    input  rv_pkg::exec_result_t      result,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]       rs1_val,
    output logic [`RV_XLEN-1:0]       rs2_val,
    output logic                      done,
    output logic [`RV_XLEN-1:0]       next_pc,
    output rv_pkg::retire_t           retire,
    output rv_pkg::trap_t             status
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_NUM];
    logic                trapped;

    // x0 is hardwired to zero
    assign rs1_val = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_val = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    assign trapped = result.trap.ecall || result.trap.ebreak || result.trap.illegal;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_REG_NUM; i++) begin
                regs[i] <= '0;
            end
            retire  <= '0;
            done    <= 1'b0;
            next_pc <= `RV_BOOT_ADDR;
            status  <= '0;
        end else begin
            retire.valid <= 1'b0;
            done         <= 1'b0;
            if (result.valid && trapped) begin
                // Flags stay set until reset, no done so fetch halts
                status <= status | result.trap;
            end else if (result.valid) begin
                if (result.rd != '0) begin
                    regs[result.rd] <= result.value;
                end
                retire.valid <= 1'b1;
                retire.rd    <= result.rd;
                retire.value <= result.value;
                retire.pc    <= result.pc;
                done         <= 1'b1;
                next_pc      <= result.next_pc;
            end
        end
    end

endmodule

//--- src/rv_core.sv
//////////////////////////////
// RV32I core top level
//////////////////////////////

`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_core (
    input  logic            aclk,
    input  logic            rst_n,
    output rv_pkg::wb_req_t ibus_req,
    input  rv_pkg::wb_rsp_t ibus_rsp,
    output rv_pkg::retire_t retire,
    output rv_pkg::trap_t   status
);

    rv_pkg::fetched_t          fetched;
    rv_pkg::decoded_t          decoded;
    rv_pkg::exec_result_t      exec_res;
    logic [`RV_REG_ADDR_W-1:0] rs1_addr;
    logic [`RV_REG_ADDR_W-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]       rs1_val;
    logic [`RV_XLEN-1:0]       rs2_val;
    logic                      done;
    logic [`RV_XLEN-1:0]       next_pc;

    rv_fetch u_fetch (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .ibus_req (ibus_req),
        .ibus_rsp (ibus_rsp),
        .fetched  (fetched),
        .done     (done),
        .next_pc  (next_pc)
    );

    rv_decode u_decode (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .fetched  (fetched),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .decoded  (decoded)
    );

    rv_execute u_execute (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .decoded (decoded),
        .result  (exec_res)
    );

    // Register file lives in the write-back stage
    rv_result u_result (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .result   (exec_res),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .done     (done),
        .next_pc  (next_pc),
        .retire   (retire),
        .status   (status)
    );

endmodule

//--- bench/tb_rv_core.sv
//////////////////////////////
// RV32I core testbench
// Random Wishbone program memory, ISA reference model and checks
//////////////////////////////

`timescale 1ns/1ps

`include "rv_settings.svh"

module tb_rv_core;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int RUNS         = 3;
    localparam int INSTRS       = 200;
    localparam int MAX_WAIT     = 3;
    localparam int HALT_CYCLES  = 20;
    localparam int SEED         = 30361;
    // Worst case per instruction is MAX_WAIT wait states plus 5 cycles
    localparam int TIMEOUT_NS   = RUNS * (INSTRS + 1) * (MAX_WAIT + 5) * CLK_PERIOD
                                + RUNS * (RESET_CYCLES + HALT_CYCLES + 4) * CLK_PERIOD
                                + 10000;

    typedef enum logic [3:0] {
        ref_add, ref_sub, ref_sll, ref_slt, ref_sltu,
        ref_xor, ref_srl, ref_sra, ref_or, ref_and
    } ref_op_e;

    // One expected retire or trap due a fixed number of cycles after ack
    typedef struct packed {
        logic [31:0]               due;
        logic                      is_trap;
        rv_pkg::trap_t             trap;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       value;
        logic [`RV_XLEN-1:0]       pc;
    } expect_t;

    logic            aclk     = 1'b0;
    logic            rst_n    = 1'b0;
    rv_pkg::wb_rsp_t ibus_rsp = '0;
    rv_pkg::wb_req_t ibus_req;
    rv_pkg::retire_t retire;
    rv_pkg::trap_t   status;

    // Reference model state
    logic [`RV_XLEN-1:0] shadow [`RV_REG_NUM];
    logic [`RV_XLEN-1:0] model_pc = `RV_BOOT_ADDR;
    expect_t             pending  = '0;
    int                  served   = 0;
    int                  waits_left = -1;
    int                  run_idx  = 0;

    // Checker state
    expect_t             exp_q [$];
    rv_pkg::trap_t       exp_status = '0;
    int unsigned         cycle = 0;
    int                  since_release = 0;
    int                  traps_seen = 0;
    logic                reset_seen = 1'b0;
    logic                halted = 1'b0;
    logic                prev_cyc = 1'b0;
    logic                prev_ack = 1'b0;
    logic                prev_retire = 1'b0;
    logic [`RV_XLEN-1:0] prev_adr = '0;

    rv_core uut (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .ibus_req (ibus_req),
        .ibus_rsp (ibus_rsp),
        .retire   (retire),
        .status   (status)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    //////////////////////////////
    // Failure reporting
    //////////////////////////////

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        stop_run($sformatf("FAIL at %0t ns: %s expected %h, got %h",
                           $time, name, expected, actual));
    endtask

    //////////////////////////////
    // ISA reference
    //////////////////////////////

    function automatic logic [31:0] alu_ref(input ref_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            ref_sub:  return a - b;
            ref_sll:  return a << b[4:0];
            ref_slt:  return {31'b0, $signed(a) < $signed(b)};
            ref_sltu: return {31'b0, a < b};
            ref_xor:  return a ^ b;
            ref_srl:  return a >> b[4:0];
            ref_sra:  return $signed(a) >>> b[4:0];
            ref_or:   return a | b;
            ref_and:  return a & b;
            default:  return a + b;
        endcase
    endfunction

    // funct3 field shared by OP and OP-IMM
    function automatic logic [2:0] funct3_of(input ref_op_e op);
        case (op)
            ref_sll:          return 3'b001;
            ref_slt:          return 3'b010;
            ref_sltu:         return 3'b011;
            ref_xor:          return 3'b100;
            ref_srl, ref_sra: return 3'b101;
            ref_or:           return 3'b110;
            ref_and:          return 3'b111;
            default:          return 3'b000;
        endcase
    endfunction

    // x0 is picked often so that zero sources and dropped writes show up
    function automatic logic [4:0] pick_reg();
        return ($urandom_range(0, 7) == 0) ? 5'd0 : 5'($urandom_range(1, 31));
    endfunction

    task automatic random_instruction(output logic [31:0] word, output expect_t e);
        int unsigned pick;
        int          off;
        ref_op_e     op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] imm;
        logic [31:0] res;
        logic [31:0] npc;
        pick = $urandom_range(0, 99);
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        off  = ($urandom_range(0, 255) - 128) * 4;
        npc  = model_pc + 32'd4;
        e    = '0;
        e.pc = model_pc;
        if (pick < 7) begin
            // Same register on both sides makes taken branches common
            if ($urandom_range(0, 1) == 1) begin
                rs2 = rs1;
            end
            f3   = ($urandom_range(0, 1) == 1) ? 3'b001 : 3'b000;
            imm  = off;
            word = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
            if ((f3 == 3'b000) == (shadow[rs1] == shadow[rs2])) begin
                npc = model_pc + imm;
            end
            rd  = '0;
            res = '0;
        end else if (pick < 10) begin
            imm  = off;
            word = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            res  = model_pc + 32'd4;
            npc  = model_pc + imm;
        end else if (pick < 20) begin
            imm  = {20'($urandom()), 12'b0};
            word = {imm[31:12], rd, 7'b0110111};
            res  = imm;
        end else if (pick < 55) begin
            // OP-IMM has no SUBI and SLTIU is not decoded
            do begin
                op = ref_op_e'(4'($urandom_range(0, 9)));
            end while (op == ref_sub || op == ref_sltu);
            f3 = funct3_of(op);
            if (f3 == 3'b001 || f3 == 3'b101) begin
                f7  = (op == ref_sra) ? 7'b0100000 : 7'b0000000;
                imm = {20'b0, f7, 5'($urandom_range(0, 31))};
            end else begin
                imm = 32'($signed(12'($urandom())));
            end
            word = {imm[11:0], rs1, f3, rd, 7'b0010011};
            res  = alu_ref(op, shadow[rs1], imm);
        end else begin
            op   = ref_op_e'(4'($urandom_range(0, 9)));
            f3   = funct3_of(op);
            f7   = (op == ref_sub || op == ref_sra) ? 7'b0100000 : 7'b0000000;
            word = {f7, rs2, rs1, f3, rd, 7'b0110011};
            res  = alu_ref(op, shadow[rs1], shadow[rs2]);
        end
        if (rd != '0) begin
            shadow[rd] = res;
        end
        model_pc = npc;
        e.rd     = rd;
        e.value  = res;
    endtask

    // Run 0 ends with ECALL, run 1 with EBREAK, run 2 with a load word
    task automatic trap_instruction(output logic [31:0] word, output expect_t e);
        e         = '0;
        e.pc      = model_pc;
        e.is_trap = 1'b1;
        if (run_idx == 0) begin
            word         = 32'h0000_0073;
            e.trap.ecall = 1'b1;
        end else if (run_idx == 1) begin
            word          = 32'h0010_0073;
            e.trap.ebreak = 1'b1;
        end else begin
            word           = {25'($urandom()), 7'b0000011};
            e.trap.illegal = 1'b1;
        end
    endtask

    //////////////////////////////
    // Wishbone memory model
    //////////////////////////////

    always @(posedge aclk) begin
        logic [31:0] word;
        expect_t     e;
        if (!rst_n) begin
            ibus_rsp.ack <= 1'b0;
            for (int i = 0; i < `RV_REG_NUM; i++) begin
                shadow[i] = '0;
            end
            model_pc   = `RV_BOOT_ADDR;
            served     = 0;
            waits_left = -1;
        end else if (ibus_rsp.ack) begin
            ibus_rsp.ack <= 1'b0;
            waits_left = -1;
        end else if (ibus_req.cyc && ibus_req.stb) begin
            if (waits_left < 0) begin
                assert (ibus_req.adr == model_pc)
                    else value_error("ibus_req.adr", model_pc, ibus_req.adr);
                assert (!ibus_req.we)
                    else value_error("ibus_req.we", 32'd0, 32'(ibus_req.we));
                waits_left = $urandom_range(0, MAX_WAIT);
            end
            if (waits_left == 0) begin
                if (served == INSTRS) begin
                    trap_instruction(word, e);
                end else begin
                    random_instruction(word, e);
                end
                served++;
                pending = e;
                ibus_rsp.ack <= 1'b1;
                ibus_rsp.dat <= word;
            end else begin
                waits_left--;
            end
        end
    end

    //////////////////////////////
    // Bus, retire and status checks
    //////////////////////////////

    always @(posedge aclk) begin
        expect_t head;
        logic    hit;
        cycle = cycle + 1;
        if (!rst_n) begin
            if (reset_seen) begin
                assert (!ibus_req.cyc) else value_error("ibus_req.cyc", 32'd0, 32'd1);
                assert (!ibus_req.stb) else value_error("ibus_req.stb", 32'd0, 32'd1);
                assert (!retire.valid) else value_error("retire.valid", 32'd0, 32'd1);
                assert (status == '0) else value_error("status", 32'd0, 32'(status));
            end
            reset_seen    = 1'b1;
            exp_q.delete();
            exp_status    = '0;
            halted        = 1'b0;
            since_release = 0;
            prev_cyc      = 1'b0;
            prev_ack      = 1'b0;
            prev_retire   = 1'b0;
        end else begin
            reset_seen = 1'b0;
            since_release++;
            if (since_release == 2) begin
                assert (ibus_req.cyc) else value_error("ibus_req.cyc", 32'd1, 32'd0);
            end
            assert (ibus_req.stb == ibus_req.cyc)
                else value_error("ibus_req.stb", 32'(ibus_req.cyc), 32'(ibus_req.stb));
            // Address held for the whole read cycle
            if (ibus_req.cyc && prev_cyc) begin
                assert (ibus_req.adr == prev_adr)
                    else value_error("ibus_req.adr", prev_adr, ibus_req.adr);
            end
            if (prev_ack || halted) begin
                assert (!ibus_req.cyc) else value_error("ibus_req.cyc", 32'd0, 32'd1);
            end
            if (prev_retire) begin
                assert (ibus_req.cyc) else value_error("ibus_req.cyc", 32'd1, 32'd0);
            end

            hit  = (exp_q.size() > 0) && (exp_q[0].due == cycle);
            head = '0;
            if (hit) begin
                head = exp_q.pop_front();
            end
            assert (retire.valid == (hit && !head.is_trap))
                else value_error("retire.valid", 32'(hit && !head.is_trap), 32'(retire.valid));
            if (hit && !head.is_trap) begin
                assert (retire.rd == head.rd)
                    else value_error("retire.rd", 32'(head.rd), 32'(retire.rd));
                assert (retire.value == head.value)
                    else value_error("retire.value", head.value, retire.value);
                assert (retire.pc == head.pc)
                    else value_error("retire.pc", head.pc, retire.pc);
            end
            if (hit && head.is_trap) begin
                exp_status = head.trap;
                traps_seen++;
            end
            assert (status == exp_status)
                else value_error("status", 32'(exp_status), 32'(status));

            // Result lands three cycles after the ack cycle
            if (ibus_rsp.ack) begin
                head     = pending;
                head.due = cycle + 3;
                exp_q.push_back(head);
                if (pending.is_trap) begin
                    halted = 1'b1;
                end
            end
            prev_cyc    = ibus_req.cyc;
            prev_adr    = ibus_req.adr;
            prev_ack    = ibus_rsp.ack;
            prev_retire = retire.valid;
        end
    end

    //////////////////////////////
    // Run control
    //////////////////////////////

    task automatic apply_reset();
        @(posedge aclk);
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        rst_n <= 1'b1;
    endtask

    initial begin
        void'($urandom(SEED));
        for (int r = 0; r < RUNS; r++) begin
            run_idx = r;
            apply_reset();
            wait (traps_seen == r + 1);
            // Core must stay halted with the bus idle
            repeat (HALT_CYCLES) @(posedge aclk);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        stop_run("Timeout: the core did not reach the end of all runs in time");
    end

endmodule

//--- tb.f
+incdir+src
src/rv_pkg.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core.sv
bench/tb_rv_core.sv

//--- Makefile
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
